//--- source/pcie_rx_consts.svh
// PCIe receive engine constants
// Beat and sideband widths, tuser SOF bit positions and the dword
// slots of a 128-bit receive beat

`ifndef PCIE_RX_CONSTS_SVH
`define PCIE_RX_CONSTS_SVH

// Stream beat from the vendor core
`define RX_DATA_W 128
`define RX_USER_W 22

// tuser start-of-frame flags
`define RX_SOF_PRESENT_BIT 14
`define RX_SOF_MID_BIT 13

// TLP header fields
`define TLP_LEN_W 10
`define DW_W 32

// Low bit of each dword slot within a beat
`define RX_DW0_LSB 0
`define RX_DW1_LSB 32
`define RX_DW2_LSB 64
`define RX_DW3_LSB 96

`endif

//--- source/pcie_rx_pkg.sv
// PCIe receive engine types
// Enums for TLP formats, decode results and FSM states, and the packed
// structs that carry beats and requests between blocks

`include "pcie_rx_consts.svh"

package pcie_rx_pkg;

    // fmt/type field of header dword 0, bits 30:24
    typedef enum logic [6:0] {
        FMT_MEM_RD32 = 7'h00,
        FMT_MEM_WR32 = 7'h40
    } tlp_fmt_type_e;

    typedef enum logic [1:0] {
        KIND_NONE,
        KIND_RD32,
        KIND_WR32
    } tlp_kind_e;

    typedef enum logic [1:0] {
        SOF_NONE,
        SOF_RIGHT,
        SOF_MID
    } sof_pos_e;

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_SECOND_BEAT,
        ST_WAIT_DONE
    } rx_state_e;

    typedef struct packed {
        logic [`RX_DATA_W-1:0] tdata;
        logic [`RX_USER_W-1:0] tuser;
    } rx_beat_t;

    // Fields needed to build a completion
    typedef struct packed {
        logic [2:0]            tc;
        logic                  td;
        logic                  ep;
        logic [1:0]            attr;
        logic [`TLP_LEN_W-1:0] len;
        logic [15:0]           rid;
        logic [7:0]            tag;
        logic [7:0]            be;
        logic [`DW_W-1:0]      addr;
    } compl_req_t;

    typedef struct packed {
        logic [`DW_W-1:0] addr;
        logic [7:0]       be;
        logic [`DW_W-1:0] data;
    } wr_req_t;

    // Decoded view of the beat on the bus this cycle
    typedef struct packed {
        sof_pos_e         sof_pos;
        tlp_kind_e        kind;
        compl_req_t       hdr;
        logic [`DW_W-1:0] addr_dw;
        logic [`DW_W-1:0] data_dw;
    } beat_view_t;

endpackage

//--- source/tlp_hdr_decode.sv
// TLP header decoder
// Locates a straddled header in a 128-bit beat, unpacks the request
// fields and classifies the TLP as a supported 32-bit read or write

`include "pcie_rx_consts.svh"

module tlp_hdr_decode
    import pcie_rx_pkg::*;
(
    input  rx_beat_t   rx_beat,
    output beat_view_t view
);

    logic             sof_present;
    logic             sof_mid;
    logic [`DW_W-1:0] dw0;
    logic [`DW_W-1:0] dw1;
    logic [`DW_W-1:0] dw2;
    logic [`DW_W-1:0] dw3;
    logic [`DW_W-1:0] hdr_dw0;
    logic [`DW_W-1:0] hdr_dw1;
    tlp_fmt_type_e    fmt_type;

    assign sof_present = rx_beat.tuser[`RX_SOF_PRESENT_BIT];
    assign sof_mid     = rx_beat.tuser[`RX_SOF_MID_BIT];

    assign dw0 = rx_beat.tdata[`RX_DW0_LSB +: `DW_W];
    assign dw1 = rx_beat.tdata[`RX_DW1_LSB +: `DW_W];
    assign dw2 = rx_beat.tdata[`RX_DW2_LSB +: `DW_W];
    assign dw3 = rx_beat.tdata[`RX_DW3_LSB +: `DW_W];

    // Start position and header dword selection
    always_comb begin
        if (!sof_present) begin
            view.sof_pos = SOF_NONE;
        end else if (sof_mid) begin
            view.sof_pos = SOF_MID;
        end else begin
            view.sof_pos = SOF_RIGHT;
        end

        if (view.sof_pos == SOF_MID) begin
            hdr_dw0 = dw2;
            hdr_dw1 = dw3;
        end else begin
            hdr_dw0 = dw0;
            hdr_dw1 = dw1;
        end

        // Right start carries address and data in the same beat,
        // otherwise they sit at the bottom of a continuation beat
        if (view.sof_pos == SOF_RIGHT) begin
            view.addr_dw = dw2;
            view.data_dw = dw3;
        end else begin
            view.addr_dw = dw0;
            view.data_dw = dw1;
        end
    end

    // Header field unpack
    always_comb begin
        view.hdr.tc   = hdr_dw0[22:20];
        view.hdr.td   = hdr_dw0[15];
        view.hdr.ep   = hdr_dw0[14];
        view.hdr.attr = hdr_dw0[13:12];
        view.hdr.len  = hdr_dw0[`TLP_LEN_W-1:0];
        view.hdr.rid  = hdr_dw1[31:16];
        view.hdr.tag  = hdr_dw1[15:8];
        view.hdr.be   = hdr_dw1[7:0];
        // Address comes from addr_dw
        view.hdr.addr = '0;
    end

    assign fmt_type = tlp_fmt_type_e'(hdr_dw0[30:24]);

    // Only single-dword 32-bit memory requests are supported
    always_comb begin
        view.kind = KIND_NONE;
        if (view.sof_pos != SOF_NONE && view.hdr.len == `TLP_LEN_W'(1)) begin
            case (fmt_type)
                FMT_MEM_RD32: view.kind = KIND_RD32;
                FMT_MEM_WR32: view.kind = KIND_WR32;
                default:      view.kind = KIND_NONE;
            endcase
        end
    end

endmodule

//--- source/rx_tlp_fsm.sv
// Receive TLP state machine
// Owns tready, gathers header and payload over one or two beats,
// issues completion or write requests and waits for them to finish

module rx_tlp_fsm
    import pcie_rx_pkg::*;
(
    input  logic       i_clk,
    input  logic       i_rst_n,
    input  logic       rx_valid,
    input  beat_view_t view,
    output logic       rx_ready,
    output logic       compl_req_valid,
    output compl_req_t compl_req,
    input  logic       compl_done,
    output logic       wr_req_valid,
    output wr_req_t    wr_req,
    input  logic       wr_busy
);

    rx_state_e  state;
    rx_state_e  state_next;
    tlp_kind_e  pend_kind;
    tlp_kind_e  pend_kind_next;
    compl_req_t hdr_q;
    compl_req_t src_hdr;
    logic       accept;
    logic       issue_rd;
    logic       issue_wr;
    logic       load_hdr;
    logic       release_wait;
    logic       ready_next;

    assign accept = rx_valid && rx_ready;

    always_comb begin
        state_next     = state;
        pend_kind_next = pend_kind;
        issue_rd       = 1'b0;
        issue_wr       = 1'b0;
        load_hdr       = 1'b0;
        release_wait   = 1'b0;
        src_hdr        = hdr_q;

        case (state)
            ST_IDLE: begin
                src_hdr = view.hdr;
                if (accept && view.sof_pos == SOF_RIGHT) begin
                    issue_rd = (view.kind == KIND_RD32);
                    issue_wr = (view.kind == KIND_WR32);
                    if (view.kind != KIND_NONE) begin
                        pend_kind_next = view.kind;
                        state_next     = ST_WAIT_DONE;
                    end
                end else if (accept && view.sof_pos == SOF_MID &&
                             view.kind != KIND_NONE) begin
                    // Header now, address and data in the next beat
                    load_hdr       = 1'b1;
                    pend_kind_next = view.kind;
                    state_next     = ST_SECOND_BEAT;
                end
            end

            ST_SECOND_BEAT: begin
                if (accept) begin
                    issue_rd   = (pend_kind == KIND_RD32);
                    issue_wr   = (pend_kind == KIND_WR32);
                    state_next = ST_WAIT_DONE;
                end
            end

            ST_WAIT_DONE: begin
                if (pend_kind == KIND_RD32) begin
                    release_wait = compl_done;
                end else begin
                    release_wait = !wr_busy;
                end
                if (release_wait) begin
                    state_next = ST_IDLE;
                end
            end

            default: state_next = ST_IDLE;
        endcase
    end

    // Back-pressure from the issuing edge until the wait is over
    assign ready_next = (state == ST_WAIT_DONE) ? release_wait : !(issue_rd || issue_wr);

    // Control state, reset asserted while i_rst_n is high
    always_ff @(posedge i_clk) begin
        if (i_rst_n) begin
            state           <= ST_IDLE;
            pend_kind       <= KIND_NONE;
            rx_ready        <= 1'b0;
            compl_req_valid <= 1'b0;
            wr_req_valid    <= 1'b0;
        end else begin
            state           <= state_next;
            pend_kind       <= pend_kind_next;
            rx_ready        <= ready_next;
            compl_req_valid <= issue_rd;
            wr_req_valid    <= issue_wr;
        end
    end

    // Header and request payload
    always_ff @(posedge i_clk) begin
        if (load_hdr) begin
            hdr_q <= view.hdr;
        end
        if (issue_rd) begin
            compl_req      <= src_hdr;
            compl_req.addr <= view.addr_dw;
        end
        if (issue_wr) begin
            wr_req.addr <= view.addr_dw;
            wr_req.be   <= src_hdr.be;
            wr_req.data <= view.data_dw;
        end
    end

endmodule

//--- source/pcie_rx_engine.sv
// PCIe endpoint receive engine
// Turns 32-bit memory read and write TLPs from the vendor core into
// completion requests and single-dword write requests

module pcie_rx_engine
    import pcie_rx_pkg::*;
(
    input  logic       i_clk,
    input  logic       i_rst_n,

    // Receive stream from the PCIe core
    input  logic       rx_valid,
    input  rx_beat_t   rx_beat,
    output logic       rx_ready,

    // Completion requests
    output logic       compl_req_valid,
    output compl_req_t compl_req,
    input  logic       compl_done,

    // Memory writes
    output logic       wr_req_valid,
    output wr_req_t    wr_req,
    input  logic       wr_busy
);

    beat_view_t beat_view;

    // Combinational decode of the current beat
    tlp_hdr_decode u_decode (
        .rx_beat (rx_beat),
        .view    (beat_view)
    );

    rx_tlp_fsm u_fsm (
        .i_clk           (i_clk),
        .i_rst_n         (i_rst_n),
        .rx_valid        (rx_valid),
        .view            (beat_view),
        .rx_ready        (rx_ready),
        .compl_req_valid (compl_req_valid),
        .compl_req       (compl_req),
        .compl_done      (compl_done),
        .wr_req_valid    (wr_req_valid),
        .wr_req          (wr_req),
        .wr_busy         (wr_busy)
    );

endmodule

//--- tests/tb_pcie_rx_engine.sv
// Testbench for the PCIe receive engine
// Replays golden beats from a data file and checks the completion and
// write requests, the rx_ready back-pressure and the release handshakes

`include "pcie_rx_consts.svh"

module tb_pcie_rx_engine
    import pcie_rx_pkg::*;
();

    timeunit 1ns;
    timeprecision 1ps;

    localparam int TIMEOUT = 200;

    logic       i_clk;
    logic       i_rst_n;
    logic       rx_valid;
    rx_beat_t   rx_beat;
    logic       rx_ready;
    logic       compl_req_valid;
    compl_req_t compl_req;
    logic       compl_done;
    logic       wr_req_valid;
    wr_req_t    wr_req;
    logic       wr_busy;
    logic       busy_at_edge;
    int         busy_len;

    pcie_rx_engine DUT (.*);

    initial begin
        i_clk = 1'b0;
        forever #4 i_clk = ~i_clk;
    end

    // Busy level as the DUT saw it on the last rising edge
    always @(posedge i_clk) begin
        busy_at_edge <= wr_busy;
    end

    // Memory side holds wr_busy for busy_len cycles after each write pulse
    initial begin
        wr_busy = 1'b0;
        forever begin
            @(negedge i_clk);
            if (wr_req_valid && busy_len > 0) begin
                wr_busy = 1'b1;
                repeat (busy_len) @(negedge i_clk);
                wr_busy = 1'b0;
            end
        end
    end

    task automatic stop_with_failure();
        $display("FAIL: see errors above");
        $fatal(1);
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            $display("FAIL %s: got 0x%0h, expected 0x%0h", name, got, exp);
            stop_with_failure();
        end
    endtask

    task automatic compare_compl(input compl_req_t got, input compl_req_t exp);
        check_value("compl_req.tc", got.tc, exp.tc);
        check_value("compl_req.td", got.td, exp.td);
        check_value("compl_req.ep", got.ep, exp.ep);
        check_value("compl_req.attr", got.attr, exp.attr);
        check_value("compl_req.len", got.len, exp.len);
        check_value("compl_req.rid", got.rid, exp.rid);
        check_value("compl_req.tag", got.tag, exp.tag);
        check_value("compl_req.be", got.be, exp.be);
        check_value("compl_req.addr", got.addr, exp.addr);
    endtask

    task automatic compare_wr(input wr_req_t got, input wr_req_t exp);
        check_value("wr_req.addr", got.addr, exp.addr);
        check_value("wr_req.be", got.be, exp.be);
        check_value("wr_req.data", got.data, exp.data);
    endtask

    task automatic wait_for_ready();
        int waited;
        waited = 0;
        while (!rx_ready) begin
            if (waited == TIMEOUT) begin
                $display("Timeout: rx_ready stayed low for %0d cycles", TIMEOUT);
                stop_with_failure();
            end
            @(negedge i_clk);
            waited++;
        end
    endtask

    // Sends one beat after a random idle gap, returns on the falling edge
    // right after the beat was taken
    task automatic send_beat(input logic expect_req, input rx_beat_t beat);
        int gap;
        busy_len = $urandom_range(0, 4);
        gap = $urandom_range(0, 3);
        repeat (gap) @(negedge i_clk);
        wait_for_ready();
        rx_valid = 1'b1;
        rx_beat  = beat;
        // rx_ready only changes on rising edges, so the next edge takes the beat
        @(negedge i_clk);
        rx_valid = 1'b0;
        rx_beat  = '0;
        if (!expect_req) begin
            check_value("rx_ready", rx_ready, 1'b1);
            check_value("compl_req_valid", compl_req_valid, 1'b0);
            check_value("wr_req_valid", wr_req_valid, 1'b0);
        end
    endtask

    task automatic wait_for_pulse(input logic is_write);
        int waited;
        waited = 0;
        while (!(is_write ? wr_req_valid : compl_req_valid)) begin
            if (waited == TIMEOUT) begin
                $display("Timeout: no request pulse within %0d cycles", TIMEOUT);
                stop_with_failure();
            end
            @(negedge i_clk);
            waited++;
        end
        if (waited != 0) begin
            $display("Request pulse came %0d cycles later than one cycle", waited);
            stop_with_failure();
        end
        check_value(is_write ? "compl_req_valid" : "wr_req_valid",
                    is_write ? compl_req_valid : wr_req_valid, 1'b0);
        check_value("rx_ready", rx_ready, 1'b0);
    endtask

    task automatic expect_compl(input compl_req_t exp);
        int delay;
        wait_for_pulse(1'b0);
        compare_compl(compl_req, exp);
        delay = $urandom_range(0, 6);
        repeat (delay) begin
            @(negedge i_clk);
            check_value("compl_req_valid", compl_req_valid, 1'b0);
            check_value("rx_ready", rx_ready, 1'b0);
        end
        compl_done = 1'b1;
        @(negedge i_clk);
        compl_done = 1'b0;
        check_value("compl_req_valid", compl_req_valid, 1'b0);
        check_value("rx_ready", rx_ready, 1'b1);
    endtask

    task automatic expect_wr(input wr_req_t exp);
        int waited;
        wait_for_pulse(1'b1);
        compare_wr(wr_req, exp);
        waited = 0;
        do begin
            if (waited == TIMEOUT) begin
                $display("Timeout: rx_ready did not return after the write");
                stop_with_failure();
            end
            @(negedge i_clk);
            waited++;
            check_value("wr_req_valid", wr_req_valid, 1'b0);
            // Ready comes back on the edge that first sees wr_busy low
            check_value("rx_ready", rx_ready, !busy_at_edge);
        end while (!rx_ready);
    endtask

    initial begin
        int                    fd;
        int                    ch;
        int                    requests;
        string                 code;
        logic                  expect_req;
        logic [`RX_USER_W-1:0] tuser_v;
        logic [`RX_DATA_W-1:0] tdata_v;
        logic [31:0]           fld [0:8];
        rx_beat_t              beat_v;
        compl_req_t            exp_c;
        wr_req_t               exp_w;

        void'($urandom(32'ha89f_250e));
        i_rst_n    = 1'b1;
        rx_valid   = 1'b0;
        rx_beat    = '0;
        compl_done = 1'b0;
        busy_len   = 0;
        requests   = 0;

        repeat (8) begin
            @(negedge i_clk);
            check_value("rx_ready", rx_ready, 1'b0);
            check_value("compl_req_valid", compl_req_valid, 1'b0);
            check_value("wr_req_valid", wr_req_valid, 1'b0);
        end
        i_rst_n = 1'b0;
        @(negedge i_clk);
        check_value("rx_ready", rx_ready, 1'b1);

        fd = $fopen("tests/pcie_rx_golden.txt", "r");
        if (fd == 0) begin
            $display("Could not open tests/pcie_rx_golden.txt");
            stop_with_failure();
        end
        while ($fscanf(fd, "%s", code) == 1) begin
            if (code.getc(0) == "#") begin
                ch = 0;
                while (ch != "\n" && ch != -1) ch = $fgetc(fd);
            end else if (code == "B") begin
                if ($fscanf(fd, "%h %h %h", expect_req, tuser_v, tdata_v) != 3) begin
                    $display("Malformed beat record in the golden file");
                    stop_with_failure();
                end
                beat_v.tdata = tdata_v;
                beat_v.tuser = tuser_v;
                send_beat(expect_req, beat_v);
            end else if (code == "C") begin
                if ($fscanf(fd, "%h %h %h %h %h %h %h %h %h", fld[0], fld[1], fld[2],
                            fld[3], fld[4], fld[5], fld[6], fld[7], fld[8]) != 9) begin
                    $display("Malformed completion record in the golden file");
                    stop_with_failure();
                end
                exp_c.tc   = fld[0][2:0];
                exp_c.td   = fld[1][0];
                exp_c.ep   = fld[2][0];
                exp_c.attr = fld[3][1:0];
                exp_c.len  = fld[4][`TLP_LEN_W-1:0];
                exp_c.rid  = fld[5][15:0];
                exp_c.tag  = fld[6][7:0];
                exp_c.be   = fld[7][7:0];
                exp_c.addr = fld[8];
                expect_compl(exp_c);
                requests++;
            end else if (code == "W") begin
                if ($fscanf(fd, "%h %h %h", fld[0], fld[1], fld[2]) != 3) begin
                    $display("Malformed write record in the golden file");
                    stop_with_failure();
                end
                exp_w.addr = fld[0];
                exp_w.be   = fld[1][7:0];
                exp_w.data = fld[2];
                expect_wr(exp_w);
                requests++;
            end else begin
                $display("Unknown record code %s in the golden file", code);
                stop_with_failure();
            end
        end
        $fclose(fd);
        if (requests == 0) begin
            $display("The golden file held no expected requests");
            stop_with_failure();
        end

        // Bus must stay quiet once the traffic is over
        repeat (4) begin
            @(negedge i_clk);
            check_value("rx_ready", rx_ready, 1'b1);
            check_value("compl_req_valid", compl_req_valid, 1'b0);
            check_value("wr_req_valid", wr_req_valid, 1'b0);
        end
        $display("PASS: all tests");
        $finish;
    end

endmodule

//--- tests/pcie_rx_golden.txt
# B expect_req tuser tdata(dw3..dw0) | C tc td ep attr len rid tag be addr
# W addr be data | values in hex, expect_req 1 on the beat that completes a request
# right-start read and write
B 1 004000 deadbeef00001a4001002a0f00201001
C 2 0 0 1 001 0100 2a 0f 00001a40
B 1 004000 cafe1234000020000100050f40008001
W 00002000 0f cafe1234
# mid-start read, header in dwords 2 and 3, address in the next beat
B 0 006000 02081103005070011111111122222222
B 1 000000 000000000000000055aa55aa00003c00
C 5 0 1 3 001 0208 11 03 00003c00
# mid-start write
B 0 006000 03007f0c401020013333333344444444
B 1 000000 000000000000000089abcdef00004008
W 00004008 0c 89abcdef
# discarded: read of length 2, IO read, beat without SOF
B 0 004000 000000000000500001000a0f00000002
B 0 004000 000000000000001001000b0f02000001
B 0 000000 000000000000600001000c0f00000001
# valid traffic straight after the discards
B 1 004000 0000000000007ffc0100400100008001
C 0 1 0 0 001 0100 40 01 00007ffc
B 1 004000 00c0ffee000001000100060140000001
W 00000100 01 00c0ffee

//--- sim.f
+incdir+source
source/pcie_rx_pkg.sv
source/tlp_hdr_decode.sv
source/rx_tlp_fsm.sv
source/pcie_rx_engine.sv
tests/tb_pcie_rx_engine.sv
